/* files.f */
common/lockstep_pkg.sv
hw/core/checksum_core.sv
hw/lockstep/shadow_reset_ctrl.sv
hw/lockstep/lockstep_delay_line.sv
hw/lockstep/lockstep_compare.sv
hw/lockstep/lockstep_checker.sv
bench/tb_lockstep_checker.sv

/* Bender.yml */
package:
  name: lockstep_checker

sources:
  # Shared package first
  - common/lockstep_pkg.sv
  # Checksum core
  - hw/core/checksum_core.sv
  # Lockstep wrapper
  - hw/lockstep/shadow_reset_ctrl.sv
  - hw/lockstep/lockstep_delay_line.sv
  - hw/lockstep/lockstep_compare.sv
  - hw/lockstep/lockstep_checker.sv
  # Testbench
  - target: simulation
    files:
      - bench/tb_lockstep_checker.sv

/* bench/tb_lockstep_checker.sv */
//////////////////////////////////////////////////////////////////////
// Lockstep checker testbench
// Runs a main checksum core against the checker from a response
// table, injects output faults and checks the three alerts
//////////////////////////////////////////////////////////////////////

module tb_lockstep_checker import lockstep_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LockstepOffset = DefaultLockstepOffset;
  localparam int unsigned AlertWindow    = LockstepOffset + 4;
  localparam int unsigned ReqTimeout     = 20;
  localparam addr_t       BootAddr       = 32'h0000_1000;

  // One memory response and the alerts it should cause
  typedef struct packed {
    word_t data;
    logic  rnd;
    logic  err;
    logic  fault;
    logic  exp_minor;
    logic  exp_internal;
    logic  exp_bus;
  } row_t;

  row_t rows [$];

  logic  clk, rst_n, fetch_enable;
  addr_t boot_addr;
  logic  mem_gnt, mem_rvalid, mem_err, fault_inj;
  word_t mem_rdata;
  logic  main_req, main_busy;
  addr_t main_addr;
  word_t main_checksum;
  logic  alert_minor, alert_internal, alert_bus;

  logic [31:0] lfsr_q;
  word_t       ref_sum;
  addr_t       ref_addr;
  int          errors, tests_run, tests_failed, test_start_errors;

  checksum_core i_main_core (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .fetch_enable_i   (fetch_enable),
    .boot_addr_i      (boot_addr),
    .data_req_o       (main_req),
    .data_addr_o      (main_addr),
    .data_gnt_i       (mem_gnt),
    .data_rvalid_i    (mem_rvalid),
    .data_rdata_i     (mem_rdata),
    .data_err_i       (mem_err),
    .checksum_o       (main_checksum),
    .core_busy_o      (main_busy),
    .alert_minor_o    (),
    .alert_major_bus_o()
  );

  // Fault injection flips checksum bit 0 on the way into the checker
  lockstep_checker #(
    .LockstepOffset(LockstepOffset)
  ) i_lockstep_checker (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .boot_addr_i           (boot_addr),
    .fetch_enable_i        (fetch_enable),
    .data_gnt_i            (mem_gnt),
    .data_rvalid_i         (mem_rvalid),
    .data_rdata_i          (mem_rdata),
    .data_err_i            (mem_err),
    .data_req_i            (main_req),
    .data_addr_i           (main_addr),
    .checksum_i            (main_checksum ^ {31'b0, fault_inj}),
    .core_busy_i           (main_busy),
    .alert_minor_o         (alert_minor),
    .alert_major_internal_o(alert_internal),
    .alert_major_bus_o     (alert_bus)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
  endtask

  function automatic string row_kind(input row_t r);
    if (r.fault) return "fault";
    if (r.err) return "bus error";
    if (r.exp_minor) return "overflow";
    if (r.rnd) return "random";
    return "clean";
  endfunction

  task automatic add_row(input word_t data, input logic rnd, input logic err,
                         input logic fault, input logic minor, input logic internal,
                         input logic bus);
    rows.push_back({data, rnd, err, fault, minor, internal, bus});
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("%-28s ok", name);
    end else begin
      tests_failed++;
      $display("%-28s %0d error(s)", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  task automatic check_alerts_low();
    check_value("alert_minor_o", 1'b0, alert_minor);
    check_value("alert_major_internal_o", 1'b0, alert_internal);
    check_value("alert_major_bus_o", 1'b0, alert_bus);
  endtask

  // Two reset cycles, then the startup window with the shadow held back
  task automatic apply_reset();
    rst_n      = 1'b0;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_err    = 1'b0;
    fault_inj  = 1'b0;
    repeat (2) begin
      next_cycle();
      check_alerts_low();
    end
    rst_n    = 1'b1;
    ref_sum  = '0;
    ref_addr = BootAddr;
    repeat (AlertWindow) begin
      next_cycle();
      check_alerts_low();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  // Grant the cycle after the request, respond the cycle after that
  task automatic respond(input word_t data, input logic is_err, input logic fault);
    int unsigned waited;
    waited = 0;
    while (!main_req && waited < ReqTimeout) begin
      next_cycle();
      waited++;
    end
    if (!main_req) report_failure("timeout waiting for a request from the main core");
    check_value("data_addr_o", ref_addr, main_addr);
    next_cycle();
    mem_gnt = 1'b1;
    next_cycle();
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b1;
    mem_rdata  = data;
    mem_err    = is_err;
    fault_inj  = fault;
    next_cycle();
    mem_rvalid = 1'b0;
    mem_err    = 1'b0;
    fault_inj  = 1'b0;
    ref_addr   = ref_addr + addr_t'(WordBytes);
    check_value("checksum_o", ref_sum, main_checksum);
  endtask

  // Rows with no expected alert watch the whole window
  task automatic wait_alerts(input logic exp_minor, input logic exp_internal,
                             input logic exp_bus);
    logic        seen_minor, seen_internal, seen_bus, done, any_exp;
    int unsigned cycles;
    seen_minor    = 1'b0;
    seen_internal = 1'b0;
    seen_bus      = 1'b0;
    done          = 1'b0;
    any_exp       = exp_minor | exp_internal | exp_bus;
    cycles        = 0;
    while (!done && cycles < AlertWindow) begin
      seen_minor    |= alert_minor;
      seen_internal |= alert_internal;
      seen_bus      |= alert_bus;
      done = any_exp && (!exp_minor || seen_minor) && (!exp_internal || seen_internal) &&
             (!exp_bus || seen_bus) && !(alert_minor | alert_internal | alert_bus);
      if (!done) begin
        next_cycle();
        cycles++;
      end
    end
    if (any_exp && !done) report_failure("expected alerts did not rise and fall in time");
    check_value("alert_minor_o", exp_minor, seen_minor);
    check_value("alert_major_internal_o", exp_internal, seen_internal);
    check_value("alert_major_bus_o", exp_bus, seen_bus);
  endtask

  task automatic apply_rows(input string pass_name);
    foreach (rows[i]) begin
      word_t       data;
      logic [32:0] wide;
      logic        carry, exp_minor;
      data = rows[i].data;
      if (rows[i].rnd) random_word(data);
      wide  = {1'b0, ref_sum} + {1'b0, data};
      carry = wide[32] & ~rows[i].err;
      if (rows[i].rnd) begin
        exp_minor = carry;
      end else begin
        exp_minor = rows[i].exp_minor;
      end
      if (!rows[i].err) ref_sum = wide[31:0];
      respond(data, rows[i].err, rows[i].fault);
      wait_alerts(exp_minor, rows[i].exp_internal, rows[i].exp_bus);
      end_test($sformatf("%s row %0d %s", pass_name, i, row_kind(rows[i])));
    end
  endtask

  // Reset while overflow and fault alerts are both active
  task automatic mid_run_reset();
    logic [32:0] wide;
    int unsigned waited;
    wide    = {1'b0, ref_sum} + 33'h0_FFFF_FFFF;
    ref_sum = wide[31:0];
    respond(32'hFFFF_FFFF, 1'b0, 1'b1);
    waited = 0;
    while (!alert_internal && waited < AlertWindow) begin
      next_cycle();
      waited++;
    end
    if (!alert_internal) report_failure("internal alert did not rise before the reset");
    check_value("alert_minor_o", wide[32], alert_minor);
    rst_n = 1'b0;
    #1;
    check_alerts_low();
    apply_reset();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n             = 1'b0;
    fetch_enable      = 1'b0;
    boot_addr         = BootAddr;
    mem_gnt           = 1'b0;
    mem_rvalid        = 1'b0;
    mem_rdata         = '0;
    mem_err           = 1'b0;
    fault_inj         = 1'b0;
    lfsr_q            = 32'd1;
    ref_sum           = '0;
    ref_addr          = BootAddr;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_start_errors = 0;

    // data, random, error, fault, then expected minor, internal, bus
    add_row(32'h0000_0010, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_0020, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row(32'hDEAD_BEEF, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    add_row(32'h1234_5678, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(32'hFFFF_FFF0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_0000, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);

    // Main core starts requesting as soon as reset ends
    fetch_enable = 1'b1;
    apply_reset();
    end_test("startup");
    apply_rows("pass 1");
    mid_run_reset();
    end_test("mid-run reset");
    apply_rows("pass 2");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* hw/lockstep/lockstep_checker.sv */
//////////////////////////////////////////////////////////////////////
// Lockstep checker
// Runs a shadow checksum core LockstepOffset cycles behind the main
// core and raises an alert when their outputs disagree
//////////////////////////////////////////////////////////////////////

module lockstep_checker import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = DefaultLockstepOffset
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  input  addr_t boot_addr_i,

  // Main core inputs
  input  logic  fetch_enable_i,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  input  word_t data_rdata_i,
  input  logic  data_err_i,

  // Main core outputs
  input  logic  data_req_i,
  input  addr_t data_addr_i,
  input  word_t checksum_i,
  input  logic  core_busy_i,

  output logic  alert_minor_o,
  output logic  alert_major_internal_o,
  output logic  alert_major_bus_o
);

  // Main outputs wait one extra cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  logic rst_shadow_n;
  logic enable_cmp;

  //////////////////////////////////////////////////////////////////////
  // Shadow reset
  //////////////////////////////////////////////////////////////////////

  shadow_reset_ctrl #(
    .LockstepOffset(LockstepOffset)
  ) u_shadow_reset_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .enable_cmp_o (enable_cmp)
  );

  //////////////////////////////////////////////////////////////////////
  // Input delay
  //////////////////////////////////////////////////////////////////////

  logic [CoreInW-1:0] main_inputs;
  logic [CoreInW-1:0] shadow_inputs;

  logic  shadow_fetch_enable;
  logic  shadow_gnt;
  logic  shadow_rvalid;
  word_t shadow_rdata;
  logic  shadow_err;

  assign main_inputs = {fetch_enable_i, data_gnt_i, data_rvalid_i, data_rdata_i, data_err_i};

  lockstep_delay_line #(
    .Width(CoreInW),
    .Depth(LockstepOffset)
  ) u_input_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(main_inputs),
    .data_o(shadow_inputs)
  );

  assign {shadow_fetch_enable, shadow_gnt, shadow_rvalid, shadow_rdata, shadow_err} =
      shadow_inputs;

  //////////////////////////////////////////////////////////////////////
  // Output delay
  //////////////////////////////////////////////////////////////////////

  logic [CoreOutW-1:0] main_outputs;
  logic [CoreOutW-1:0] main_outputs_dly;

  assign main_outputs = {data_req_i, data_addr_i, checksum_i, core_busy_i};

  lockstep_delay_line #(
    .Width(CoreOutW),
    .Depth(OutputsOffset)
  ) u_output_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(main_outputs),
    .data_o(main_outputs_dly)
  );

  //////////////////////////////////////////////////////////////////////
  // Shadow core
  //////////////////////////////////////////////////////////////////////

  logic  shadow_req;
  addr_t shadow_addr;
  word_t shadow_checksum;
  logic  shadow_busy;
  logic  shadow_alert_minor;
  logic  shadow_alert_bus;

  // Boot address is static, so it skips the delay line
  checksum_core u_shadow_core (
    .clk_i            (clk_i),
    .rst_ni           (rst_shadow_n),
    .fetch_enable_i   (shadow_fetch_enable),
    .boot_addr_i      (boot_addr_i),
    .data_req_o       (shadow_req),
    .data_addr_o      (shadow_addr),
    .data_gnt_i       (shadow_gnt),
    .data_rvalid_i    (shadow_rvalid),
    .data_rdata_i     (shadow_rdata),
    .data_err_i       (shadow_err),
    .checksum_o       (shadow_checksum),
    .core_busy_o      (shadow_busy),
    .alert_minor_o    (shadow_alert_minor),
    .alert_major_bus_o(shadow_alert_bus)
  );

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  lockstep_compare u_lockstep_compare (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .enable_cmp_i          (enable_cmp),
    .shadow_outputs_i      ({shadow_req, shadow_addr, shadow_checksum, shadow_busy}),
    .main_outputs_i        (main_outputs_dly),
    .shadow_alert_minor_i  (shadow_alert_minor),
    .shadow_alert_bus_i    (shadow_alert_bus),
    .alert_minor_o         (alert_minor_o),
    .alert_major_internal_o(alert_major_internal_o),
    .alert_major_bus_o     (alert_major_bus_o)
  );

endmodule

/* hw/lockstep/lockstep_compare.sv */
//////////////////////////////////////////////////////////////////////
// Lockstep comparator
// Registers the shadow outputs, checks them against the delayed main
// outputs and merges the shadow alerts
//////////////////////////////////////////////////////////////////////

module lockstep_compare import lockstep_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_cmp_i,

  input  logic [CoreOutW-1:0] shadow_outputs_i,
  // Main outputs, already aligned with the registered shadow outputs
  input  logic [CoreOutW-1:0] main_outputs_i,

  input  logic                shadow_alert_minor_i,
  input  logic                shadow_alert_bus_i,

  output logic                alert_minor_o,
  output logic                alert_major_internal_o,
  output logic                alert_major_bus_o
);

  logic [CoreOutW-1:0] shadow_outputs_q;
  logic                outputs_differ;

  // Shadow output register, one cycle that the main path matches
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_outputs_q <= '0;
    end else begin
      shadow_outputs_q <= shadow_outputs_i;
    end
  end

  assign outputs_differ = (shadow_outputs_q != main_outputs_i);

  //////////////////////////////////////////////////////////////////////
  // Alert merging
  //////////////////////////////////////////////////////////////////////

  // No comparison until the shadow has left reset and settled
  assign alert_major_internal_o = enable_cmp_i & outputs_differ;

  // Bus and overflow alerts come from the shadow only
  assign alert_major_bus_o = shadow_alert_bus_i;
  assign alert_minor_o     = shadow_alert_minor_i;

endmodule

/* hw/lockstep/lockstep_delay_line.sv */
//////////////////////////////////////////////////////////////////////
// Lockstep delay line
// Shift register of Depth stages that clears to zero on reset
//////////////////////////////////////////////////////////////////////

module lockstep_delay_line import lockstep_pkg::*; #(
  parameter int unsigned Width = CoreInW,
  parameter int unsigned Depth = DefaultLockstepOffset
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Stage 0 takes the input, the last stage drives the output
  logic [Width-1:0] stage_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

/* hw/lockstep/shadow_reset_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Shadow reset control
// Holds the shadow core in reset for LockstepOffset cycles, then
// enables output comparison one cycle after release
//////////////////////////////////////////////////////////////////////

module shadow_reset_ctrl import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = DefaultLockstepOffset
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic enable_cmp_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  logic [CntW-1:0] cnt_q, cnt_d;
  logic            release_d;
  logic            release_q;
  logic            enable_cmp_q;

  // Counter saturates at LockstepOffset-1
  assign release_d = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d     = release_d ? cnt_q : cnt_q + 1'b1;

  // rst_ni clears everything at once, so the shadow drops into reset
  // immediately while release only happens on a clock edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      release_q    <= 1'b0;
      enable_cmp_q <= 1'b0;
    end else begin
      cnt_q        <= cnt_d;
      release_q    <= release_d;
      enable_cmp_q <= release_q;
    end
  end

  assign rst_shadow_no = release_q;
  assign enable_cmp_o  = enable_cmp_q;

endmodule

/* hw/core/checksum_core.sv */
//////////////////////////////////////////////////////////////////////
// Checksum core
// Reads consecutive words over a req/gnt/rvalid port and sums them,
// alerting on bus error responses and on carry out of the sum
//////////////////////////////////////////////////////////////////////

module checksum_core import lockstep_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  input  logic  fetch_enable_i,
  input  addr_t boot_addr_i,

  // Memory port
  output logic  data_req_o,
  output addr_t data_addr_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  input  word_t data_rdata_i,
  input  logic  data_err_i,

  output word_t checksum_o,
  output logic  core_busy_o,
  output logic  alert_minor_o,
  output logic  alert_major_bus_o
);

  core_state_e state_q, state_d;
  addr_t       addr_q, addr_d;
  word_t       sum_q, sum_d;
  word_t       sum_add;
  logic        sum_carry;
  logic        resp_valid;
  logic        overflow;
  logic        minor_q;

  // A response only counts while one is outstanding
  assign resp_valid = (state_q == WAIT_RESP) & data_rvalid_i;

  assign {sum_carry, sum_add} = {1'b0, sum_q} + {1'b0, data_rdata_i};
  assign overflow             = resp_valid & ~data_err_i & sum_carry;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    sum_d   = sum_q;

    case (state_q)
      IDLE: begin
        if (fetch_enable_i) begin
          addr_d  = boot_addr_i;
          state_d = REQUEST;
        end
      end

      // Request stays up until the memory takes it
      REQUEST: begin
        if (data_gnt_i) begin
          state_d = WAIT_RESP;
        end
      end

      WAIT_RESP: begin
        if (data_rvalid_i) begin
          // Errored data never enters the sum
          if (!data_err_i) begin
            sum_d = sum_add;
          end
          addr_d  = addr_q + addr_t'(WordBytes);
          state_d = fetch_enable_i ? REQUEST : IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      sum_q   <= '0;
      minor_q <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      sum_q   <= sum_d;
      minor_q <= overflow;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign data_req_o  = (state_q == REQUEST);
  assign data_addr_o = addr_q;
  assign checksum_o  = sum_q;
  assign core_busy_o = (state_q != IDLE);

  // Overflow pulse lags the response by one cycle
  assign alert_minor_o     = minor_q;
  assign alert_major_bus_o = resp_valid & data_err_i;

endmodule

/* common/lockstep_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Lockstep checker shared definitions
// Word and address types, default widths and the core state encoding
//////////////////////////////////////////////////////////////////////

package lockstep_pkg;

  // Data word and running checksum
  typedef logic [31:0] word_t;

  // Byte address on the memory port
  typedef logic [31:0] addr_t;

  // Cycles between the main core and its shadow, at least 2
  parameter int unsigned DefaultLockstepOffset = 2;

  // Address step per word read
  parameter int unsigned WordBytes = 4;

  // Checksum core FSM
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RESP
  } core_state_e;

  ////////////////////////////////////////////////////////////////////
  // Packed vector widths
  ////////////////////////////////////////////////////////////////////

  // fetch enable, gnt, rvalid, rdata, err
  parameter int unsigned CoreInW = 1 + 1 + 1 + $bits(word_t) + 1;

  // req, addr, checksum, busy
  parameter int unsigned CoreOutW = 1 + $bits(addr_t) + $bits(word_t) + 1;

endpackage
